// ==== common/dispatch_cfg.svh ====
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// version bits per architectural register.
`define RNBIT 2

// entries in the dispatch fifo, power of two.
`define DISPATCH_FIFO_DP 8

`endif

// ==== common/dispatch_pkg.sv ====
`default_nettype none

package dispatch_pkg;

`include "dispatch_cfg.svh"

	// order matters, dispatch classifies by range.
	typedef enum logic [5:0] {
		op_lui, op_auipc,
		op_jal, op_jalr, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld,
		op_sb, op_sh, op_sw, op_sd,
		op_addi, op_addiw, op_slti, op_sltiu, op_xori, op_ori, op_andi,
		op_slli, op_slliw, op_srli, op_srliw, op_srai, op_sraiw,
		op_add, op_addw, op_sub, op_subw, op_sll, op_sllw, op_slt, op_sltu,
		op_xor, op_srl, op_srlw, op_sra, op_sraw, op_or, op_and,
		op_fence, op_fence_i,
		op_ecall, op_ebreak,
		op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci,
		op_illegal
	} micro_op_e;

	typedef enum logic [2:0] {
		unit_alu,
		unit_blu,
		unit_lsu,
		unit_csr,
		unit_oth
	} exec_unit_e;

	typedef logic [4:0] arch_reg_t;
	typedef logic [`RNBIT-1:0] version_t;
	typedef logic [5+`RNBIT-1:0] phys_reg_t; // {arch index, version}.

	typedef struct packed {
		micro_op_e op;
		logic [63:0] pc;
		logic [63:0] imm;
		phys_reg_t rd;
		phys_reg_t rs1;
		phys_reg_t rs2;
	} rename_entry_t;

endpackage

`default_nettype wire

// ==== logic/rv64_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv64_decoder import dispatch_pkg::*; (
	input  wire [31:0] instr,
	output micro_op_e  op,
	output logic [63:0] imm,
	output arch_reg_t  rd,
	output arch_reg_t  rs1,
	output arch_reg_t  rs2
);

	localparam logic [6:0] OPC_LUI = 7'b0110111, OPC_AUIPC = 7'b0010111,
		OPC_JAL = 7'b1101111, OPC_JALR = 7'b1100111, OPC_BRANCH = 7'b1100011,
		OPC_LOAD = 7'b0000011, OPC_STORE = 7'b0100011, OPC_OP_IMM = 7'b0010011,
		OPC_OP_IMM32 = 7'b0011011, OPC_OP = 7'b0110011, OPC_OP32 = 7'b0111011,
		OPC_MISC_MEM = 7'b0001111, OPC_SYSTEM = 7'b1110011;

	wire [6:0] opcode = instr[6:0];
	wire [2:0] funct3 = instr[14:12];
	wire [6:0] funct7 = instr[31:25];

	wire [63:0] imm_i = {{52{instr[31]}}, instr[31:20]};
	wire [63:0] imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	wire [63:0] imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	wire [63:0] imm_u = {{32{instr[31]}}, instr[31:12], 12'd0};
	wire [63:0] imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	logic use_rd;
	logic use_rs1;
	logic use_rs2;

	always_comb begin
		op = op_illegal;
		case (opcode)
		OPC_LUI:   op = op_lui;
		OPC_AUIPC: op = op_auipc;
		OPC_JAL:   op = op_jal;
		OPC_JALR:  if (funct3 == 3'b000) op = op_jalr;
		OPC_BRANCH: begin
			case (funct3)
			3'b000: op = op_beq;
			3'b001: op = op_bne;
			3'b100: op = op_blt;
			3'b101: op = op_bge;
			3'b110: op = op_bltu;
			3'b111: op = op_bgeu;
			default: op = op_illegal;
			endcase
		end
		OPC_LOAD: begin
			case (funct3)
			3'b000: op = op_lb;
			3'b001: op = op_lh;
			3'b010: op = op_lw;
			3'b011: op = op_ld;
			3'b100: op = op_lbu;
			3'b101: op = op_lhu;
			3'b110: op = op_lwu;
			default: op = op_illegal;
			endcase
		end
		OPC_STORE: begin
			case (funct3)
			3'b000: op = op_sb;
			3'b001: op = op_sh;
			3'b010: op = op_sw;
			3'b011: op = op_sd;
			default: op = op_illegal;
			endcase
		end
		OPC_OP_IMM: begin
			case (funct3)
			3'b000: op = op_addi;
			3'b010: op = op_slti;
			3'b011: op = op_sltiu;
			3'b100: op = op_xori;
			3'b110: op = op_ori;
			3'b111: op = op_andi;
			3'b001: if (instr[31:26] == 6'b000000) op = op_slli;
			3'b101: begin
				if (instr[31:26] == 6'b000000)
					op = op_srli;
				else if (instr[31:26] == 6'b010000)
					op = op_srai;
			end
			default: op = op_illegal;
			endcase
		end
		OPC_OP_IMM32: begin
			casez ({funct7, funct3})
			10'b???????_000: op = op_addiw;
			10'b0000000_001: op = op_slliw;
			10'b0000000_101: op = op_srliw;
			10'b0100000_101: op = op_sraiw;
			default: op = op_illegal;
			endcase
		end
		OPC_OP: begin
			case ({funct7, funct3})
			10'b0000000_000: op = op_add;
			10'b0100000_000: op = op_sub;
			10'b0000000_001: op = op_sll;
			10'b0000000_010: op = op_slt;
			10'b0000000_011: op = op_sltu;
			10'b0000000_100: op = op_xor;
			10'b0000000_101: op = op_srl;
			10'b0100000_101: op = op_sra;
			10'b0000000_110: op = op_or;
			10'b0000000_111: op = op_and;
			default: op = op_illegal;
			endcase
		end
		OPC_OP32: begin
			case ({funct7, funct3})
			10'b0000000_000: op = op_addw;
			10'b0100000_000: op = op_subw;
			10'b0000000_001: op = op_sllw;
			10'b0000000_101: op = op_srlw;
			10'b0100000_101: op = op_sraw;
			default: op = op_illegal;
			endcase
		end
		OPC_MISC_MEM: begin
			if (funct3 == 3'b000)
				op = op_fence;
			else if (funct3 == 3'b001)
				op = op_fence_i;
		end
		OPC_SYSTEM: begin
			case (funct3)
			3'b000: begin
				if (instr[31:20] == 12'h000)
					op = op_ecall;
				else if (instr[31:20] == 12'h001)
					op = op_ebreak;
			end
			3'b001: op = op_csrrw;
			3'b010: op = op_csrrs;
			3'b011: op = op_csrrc;
			3'b101: op = op_csrrwi;
			3'b110: op = op_csrrsi;
			3'b111: op = op_csrrci;
			default: op = op_illegal;
			endcase
		end
		default: op = op_illegal;
		endcase
	end

	always_comb begin
		case (opcode)
		OPC_LUI, OPC_AUIPC: imm = imm_u;
		OPC_JAL:            imm = imm_j;
		OPC_BRANCH:         imm = imm_b;
		OPC_STORE:          imm = imm_s;
		OPC_OP, OPC_OP32:   imm = '0;
		OPC_SYSTEM:         imm = {52'd0, instr[31:20]}; // csr address.
		default:            imm = imm_i;
		endcase
		if (op inside {op_slli, op_srli, op_srai, op_slliw, op_srliw, op_sraiw})
			imm = {58'd0, instr[25:20]}; // shamt.
		if (op == op_illegal)
			imm = '0;
	end

	assign use_rd = !(op inside {op_illegal, op_fence, op_fence_i, op_ecall, op_ebreak})
		&& !(opcode inside {OPC_BRANCH, OPC_STORE});
	assign use_rs1 = !(op inside {op_illegal, op_lui, op_auipc, op_jal, op_fence, op_fence_i,
		op_ecall, op_ebreak, op_csrrwi, op_csrrsi, op_csrrci});
	assign use_rs2 = op != op_illegal
		&& opcode inside {OPC_BRANCH, OPC_STORE, OPC_OP, OPC_OP32};

	assign rd  = use_rd  ? instr[11:7]  : '0;
	assign rs1 = use_rs1 ? instr[19:15] : '0;
	assign rs2 = use_rs2 ? instr[24:20] : '0;

endmodule

`default_nettype wire

// ==== rename/rename_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_stage import dispatch_pkg::*; (
	input  wire            CLK,
	input  wire            rst_n,
	input  wire            instr_valid,
	output logic           instr_ready,
	input  wire [63:0]     pc,
	input  wire micro_op_e op,
	input  wire [63:0]     imm,
	input  wire arch_reg_t arch_rd,
	input  wire arch_reg_t arch_rs1,
	input  wire arch_reg_t arch_rs2,
	output logic           ren_valid,
	output rename_entry_t  ren_entry,
	input  wire            ren_ready,
	input  wire            commit_valid,
	input  wire arch_reg_t commit_rd
);

	version_t ver [32]; // current version.
	version_t cnt [32]; // versions still in flight.

	logic accept;
	logic out_free;
	logic stall;
	version_t rd_next;

	assign rd_next  = ver[arch_rd] + 1'b1; // wraps.
	assign stall    = arch_rd != '0 && cnt[arch_rd] == '1;
	assign out_free = !ren_valid || ren_ready;
	assign instr_ready = out_free && !stall;
	assign accept   = instr_valid && instr_ready;

	// x0 is skipped, stays at version 0.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				ver[i] <= '0;
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 1; i < 32; i++) begin
				if (accept && arch_rd == i)
					ver[i] <= rd_next;
				cnt[i] <= cnt[i] + version_t'(accept && arch_rd == i)
					- version_t'(commit_valid && commit_rd == i && cnt[i] != '0);
			end
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			ren_valid <= 1'b0;
		else if (out_free)
			ren_valid <= accept; // refill while draining.
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			ren_entry.op  <= op;
			ren_entry.pc  <= pc;
			ren_entry.imm <= imm;
			ren_entry.rd  <= (arch_rd == '0) ? '0 : {arch_rd, rd_next};
			ren_entry.rs1 <= {arch_rs1, ver[arch_rs1]};
			ren_entry.rs2 <= {arch_rs2, ver[arch_rs2]};
		end
	end

endmodule

`default_nettype wire

// ==== logic/dispatch_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_fifo import dispatch_pkg::*; #(
	parameter int DP = `DISPATCH_FIFO_DP
) (
	input  wire           CLK,
	input  wire           rst_n,
	input  wire           ren_valid,
	input  wire rename_entry_t ren_entry,
	output logic          ren_ready,
	output logic          dsp_valid,
	output rename_entry_t dsp_entry,
	input  wire           dsp_ready
);

	localparam int AW = $clog2(DP);

	rename_entry_t mem [DP];
	logic [AW:0] wr_ptr; // extra msb tells full from empty.
	logic [AW:0] rd_ptr;
	logic full;
	logic push;
	logic pop;

	assign full      = wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]};
	assign dsp_valid = wr_ptr != rd_ptr;
	assign dsp_entry = mem[rd_ptr[AW-1:0]];
	assign pop       = dsp_valid && dsp_ready;
	assign ren_ready = !full || pop; // full only takes a push alongside a pop.
	assign push      = ren_valid && ren_ready;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= ren_entry;
	end

endmodule

`default_nettype wire

// ==== dispatch/dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch import dispatch_pkg::*; (
	input  wire           dsp_valid,
	input  wire rename_entry_t dsp_entry,
	output logic          dsp_ready,
	output logic          alu_valid,
	input  wire           alu_ready,
	output logic          blu_valid,
	input  wire           blu_ready,
	output logic          lsu_valid,
	input  wire           lsu_ready,
	output logic          csr_valid,
	input  wire           csr_ready,
	output logic          oth_valid,
	input  wire           oth_ready,
	output micro_op_e     issue_op,
	output logic [63:0]   issue_pc,
	output logic [63:0]   issue_imm,
	output phys_reg_t     issue_rd,
	output phys_reg_t     issue_rs1,
	output phys_reg_t     issue_rs2,
	output logic          iorder_valid,
	input  wire           iorder_ready,
	output logic [63:0]   iorder_pc,
	output phys_reg_t     iorder_rd
);

	exec_unit_e unit;
	logic unit_ready;
	logic go;

	// ranges follow the enum order.
	always_comb begin
		if (dsp_entry.op inside {[op_jal:op_bgeu]})
			unit = unit_blu;
		else if (dsp_entry.op inside {[op_lb:op_sd]})
			unit = unit_lsu;
		else if (dsp_entry.op inside {[op_csrrw:op_csrrci]})
			unit = unit_csr;
		else if (dsp_entry.op inside {op_fence, op_fence_i, op_ecall, op_ebreak, op_illegal})
			unit = unit_oth;
		else
			unit = unit_alu;
	end

	always_comb begin
		case (unit)
		unit_alu: unit_ready = alu_ready;
		unit_blu: unit_ready = blu_ready;
		unit_lsu: unit_ready = lsu_ready;
		unit_csr: unit_ready = csr_ready;
		default:  unit_ready = oth_ready;
		endcase
	end

	// issue and iorder move together or not at all.
	assign dsp_ready    = unit_ready && iorder_ready;
	assign go           = dsp_valid && dsp_ready;
	assign alu_valid    = go && unit == unit_alu;
	assign blu_valid    = go && unit == unit_blu;
	assign lsu_valid    = go && unit == unit_lsu;
	assign csr_valid    = go && unit == unit_csr;
	assign oth_valid    = go && unit == unit_oth;
	assign iorder_valid = go;

	assign issue_op  = dsp_entry.op;
	assign issue_pc  = dsp_entry.pc;
	assign issue_imm = dsp_entry.imm;
	assign issue_rd  = dsp_entry.rd;
	assign issue_rs1 = dsp_entry.rs1;
	assign issue_rs2 = dsp_entry.rs2;
	assign iorder_pc = dsp_entry.pc;
	assign iorder_rd = dsp_entry.rd;

endmodule

`default_nettype wire

// ==== logic/dispatch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_top import dispatch_pkg::*; (
	input  wire            CLK,
	input  wire            rst_n,
	input  wire            instr_valid,
	output wire            instr_ready,
	input  wire [31:0]     instr,
	input  wire [63:0]     pc,
	input  wire            commit_valid,
	input  wire arch_reg_t commit_rd,
	output wire            alu_valid,
	input  wire            alu_ready,
	output wire            blu_valid,
	input  wire            blu_ready,
	output wire            lsu_valid,
	input  wire            lsu_ready,
	output wire            csr_valid,
	input  wire            csr_ready,
	output wire            oth_valid,
	input  wire            oth_ready,
	output wire micro_op_e issue_op,
	output wire [63:0]     issue_pc,
	output wire [63:0]     issue_imm,
	output wire phys_reg_t issue_rd,
	output wire phys_reg_t issue_rs1,
	output wire phys_reg_t issue_rs2,
	output wire            iorder_valid,
	input  wire            iorder_ready,
	output wire [63:0]     iorder_pc,
	output wire phys_reg_t iorder_rd
);

	wire micro_op_e op;
	wire [63:0] imm;
	wire arch_reg_t arch_rd;
	wire arch_reg_t arch_rs1;
	wire arch_reg_t arch_rs2;
	wire ren_valid;
	wire ren_ready;
	wire rename_entry_t ren_entry;
	wire dsp_valid;
	wire dsp_ready;
	wire rename_entry_t dsp_entry;

	rv64_decoder u_decoder (.*, .rd(arch_rd), .rs1(arch_rs1), .rs2(arch_rs2));

	rename_stage u_rename (.*);

	dispatch_fifo #(.DP(`DISPATCH_FIFO_DP)) u_fifo (.*);

	dispatch u_dispatch (.*);

endmodule

`default_nettype wire

// ==== dv/dispatch_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_assert import dispatch_pkg::*; (
	input wire            CLK,
	input wire            rst_n,
	input wire            alu_valid,
	input wire            blu_valid,
	input wire            lsu_valid,
	input wire            csr_valid,
	input wire            oth_valid,
	input wire            iorder_valid,
	input wire            dsp_valid,
	input wire            dsp_ready,
	input wire micro_op_e issue_op,
	input wire [63:0]     issue_pc,
	input wire [63:0]     issue_imm,
	input wire phys_reg_t issue_rd,
	input wire phys_reg_t issue_rs1,
	input wire phys_reg_t issue_rs2
);

	wire [4:0] valids = {oth_valid, csr_valid, lsu_valid, blu_valid, alu_valid};
	wire held = dsp_valid && !dsp_ready; // head entry waits for its readies.

	a_one_unit: assert property (@(posedge CLK) disable iff (!rst_n) $onehot0(valids))
		else $error("more than one unit valid");

	a_iorder_follows: assert property (@(posedge CLK) disable iff (!rst_n)
		iorder_valid == |valids)
		else $error("iorder_valid differs from the unit valids");

	// fields hold while a transfer waits.
	a_fields_stable: assert property (@(posedge CLK) disable iff (!rst_n)
		held |=> $stable({issue_op, issue_pc, issue_imm, issue_rd, issue_rs1, issue_rs2}))
		else $error("issue fields changed while a valid was held");

	a_quiet_in_reset: assert property (@(posedge CLK) !rst_n |-> !(|valids) && !iorder_valid)
		else $error("valid high during reset");

endmodule

// dispatch itself has no clock, so the checker sits on the top level.
bind dispatch_top dispatch_assert u_assert (.*);

`default_nettype wire

// ==== dv/dispatch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb import dispatch_pkg::*; ();

	localparam int WAIT_MAX = 200;
	localparam logic [31:0] SEED = 32'h48c7a381;
	localparam logic [6:0] OP_IMM = 7'b0010011;

	typedef struct packed {
		exec_unit_e unit;
		rename_entry_t e;
		logic [63:0] ipc;
		phys_reg_t ird;
		logic [31:0] cyc;
	} issue_rec_t;

	logic CLK;
	logic rst_n;
	logic instr_valid;
	logic instr_ready;
	logic [31:0] instr;
	logic [63:0] pc;
	logic commit_valid;
	arch_reg_t commit_rd;
	logic alu_valid, blu_valid, lsu_valid, csr_valid, oth_valid;
	logic alu_ready, blu_ready, lsu_ready, csr_ready, oth_ready;
	micro_op_e issue_op;
	logic [63:0] issue_pc;
	logic [63:0] issue_imm;
	phys_reg_t issue_rd;
	phys_reg_t issue_rs1;
	phys_reg_t issue_rs2;
	logic iorder_valid;
	logic iorder_ready;
	logic [63:0] iorder_pc;
	phys_reg_t iorder_rd;

	issue_rec_t exp_q [$];
	issue_rec_t got_q [$];
	version_t model_ver [32]; // reference version table.
	int model_cnt [32];
	int errors;
	int checks;
	int tests;
	logic [31:0] cyc;
	logic [31:0] rdy_seed;
	logic [31:0] dat_seed;
	logic rand_stall;

	dispatch_top u_dut (.*);

	always #4 CLK = ~CLK;

	always @(negedge CLK) cyc <= cyc + 1; // edge index, read on rising edges.

	always @(negedge CLK) begin
		if (rand_stall) begin
			rdy_seed = lcg(rdy_seed);
			{alu_ready, blu_ready, lsu_ready, csr_ready, oth_ready, iorder_ready} =
				rdy_seed[31:26] | rdy_seed[25:20];
		end
	end

	// records every transfer on the issue side.
	always @(posedge CLK) begin : monitor
		logic [4:0] vals;
		logic [4:0] rdys;
		int n;
		int idx;
		issue_rec_t r;
		vals = {oth_valid, csr_valid, lsu_valid, blu_valid, alu_valid};
		rdys = {oth_ready, csr_ready, lsu_ready, blu_ready, alu_ready};
		n = 0;
		idx = 0;
		for (int i = 0; i < 5; i++) begin
			if (vals[i]) begin
				n++;
				idx = i;
			end
		end
		if (!rst_n && (n != 0 || iorder_valid)) begin
			errors++;
			$display("%0t ns: a valid was high during reset", $time);
		end else if (n != 0 || iorder_valid) begin
			if (n != 1 || !iorder_valid) begin
				errors++;
				$display("%0t ns: unit valids and iorder_valid out of step", $time);
			end
			if ((vals & ~rdys) != 0 || !iorder_ready) begin
				errors++;
				$display("%0t ns: issue valid raised while a ready was low", $time);
			end
			r.unit = exec_unit_e'(idx);
			r.e.op = issue_op;
			r.e.pc = issue_pc;
			r.e.imm = issue_imm;
			r.e.rd = issue_rd;
			r.e.rs1 = issue_rs1;
			r.e.rs2 = issue_rs2;
			r.ipc = iorder_pc;
			r.ird = iorder_rd;
			r.cyc = cyc;
			got_q.push_back(r);
		end
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic exec_unit_e unit_of(input micro_op_e op);
		case (op)
		op_jal, op_jalr, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
			return unit_blu;
		op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld, op_sb, op_sh, op_sw, op_sd:
			return unit_lsu;
		op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci:
			return unit_csr;
		op_fence, op_fence_i, op_ecall, op_ebreak, op_illegal:
			return unit_oth;
		default:
			return unit_alu;
		endcase
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input arch_reg_t rs2, rs1,
		input logic [2:0] f3, input arch_reg_t rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input arch_reg_t rs1,
		input logic [2:0] f3, input arch_reg_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input arch_reg_t rs2, rs1,
		input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input arch_reg_t rs2, rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input arch_reg_t rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input arch_reg_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic check_unit(input exec_unit_e got, exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s is %s, expected %s", $time, what, got.name(),
				exp.name());
		end
	endtask

	task automatic check_op(input micro_op_e got, exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s is %s, expected %s", $time, what, got.name(),
				exp.name());
		end
	endtask

	task automatic check_tag(input phys_reg_t got, exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s is x%0d.v%0d, expected x%0d.v%0d", $time, what,
				got[$bits(got)-1 -: 5], version_t'(got), exp[$bits(exp)-1 -: 5],
				version_t'(exp));
		end
	endtask

	task automatic check_word(input logic [63:0] got, exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic timed_out(input string what);
		errors++;
		$display("timeout at %0t ns: %s never arrived", $time, what);
		finish_run();
	endtask

	task automatic finish_test(input string name, input int err0);
		tests++;
		if (errors == err0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err0);
	endtask

	// waits for the handshake, then predicts the renamed entry.
	task automatic wait_accept(input logic [63:0] p, input micro_op_e op,
		input logic [63:0] imm, input arch_reg_t rd, rs1, rs2);
		int n;
		issue_rec_t r;
		n = 0;
		@(posedge CLK);
		while (!instr_ready) begin
			n++;
			if (n == WAIT_MAX)
				timed_out("instr_ready");
			@(posedge CLK);
		end
		r.unit = unit_of(op);
		r.e.op = op;
		r.e.pc = p;
		r.e.imm = imm;
		r.e.rs1 = {rs1, model_ver[rs1]}; // sources before the rd update.
		r.e.rs2 = {rs2, model_ver[rs2]};
		if (rd == '0) begin
			r.e.rd = '0;
		end else begin
			model_ver[rd] = model_ver[rd] + 1'b1;
			model_cnt[rd]++;
			r.e.rd = {rd, model_ver[rd]};
		end
		r.ipc = p;
		r.ird = r.e.rd;
		r.cyc = cyc;
		exp_q.push_back(r);
	endtask

	task automatic send(input logic [31:0] w, input logic [63:0] p, input micro_op_e op,
		input logic [63:0] imm, input arch_reg_t rd, rs1, rs2);
		@(negedge CLK);
		instr_valid = 1'b1;
		instr = w;
		pc = p;
		wait_accept(p, op, imm, rd, rs1, rs2);
	endtask

	task automatic idle();
		@(negedge CLK);
		instr_valid = 1'b0;
	endtask

	task automatic commit(input arch_reg_t r);
		@(negedge CLK);
		commit_valid = 1'b1;
		commit_rd = r;
		@(negedge CLK);
		commit_valid = 1'b0;
		if (model_cnt[r] > 0)
			model_cnt[r]--;
	endtask

	task automatic release_all();
		for (int r = 1; r < 32; r++) begin
			while (model_cnt[r] > 0)
				commit(arch_reg_t'(r));
		end
	endtask

	task automatic compare_issued(input bit check_lat);
		int n;
		issue_rec_t g;
		issue_rec_t e;
		n = 0;
		while (got_q.size() < exp_q.size()) begin
			@(negedge CLK);
			n++;
			if (n == WAIT_MAX)
				timed_out("issue valid");
		end
		repeat (4) @(negedge CLK); // room for a duplicate to show up.
		check_count(got_q.size(), exp_q.size(), "issued entries");
		while (exp_q.size() > 0 && got_q.size() > 0) begin
			e = exp_q.pop_front();
			g = got_q.pop_front();
			check_unit(g.unit, e.unit, "unit");
			check_op(g.e.op, e.e.op, "issue_op");
			check_word(g.e.pc, e.e.pc, "issue_pc");
			check_word(g.e.imm, e.e.imm, "issue_imm");
			check_tag(g.e.rd, e.e.rd, "issue_rd");
			check_tag(g.e.rs1, e.e.rs1, "issue_rs1");
			check_tag(g.e.rs2, e.e.rs2, "issue_rs2");
			check_word(g.ipc, e.ipc, "iorder_pc");
			check_tag(g.ird, e.ird, "iorder_rd");
			if (check_lat)
				check_count(g.cyc - e.cyc, 2, "edges from accept to issue");
		end
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic test_classify();
		int err0;
		err0 = errors;
		send(enc_i(12'hffb, 5'd2, 3'b000, 5'd1, OP_IMM), 64'h1000, op_addi,
			64'hffff_ffff_ffff_fffb, 5'd1, 5'd2, 5'd0);
		send(enc_u(20'h80000, 5'd3, 7'b0110111), 64'h1004, op_lui,
			64'hffff_ffff_8000_0000, 5'd3, 5'd0, 5'd0);
		send(enc_i(12'h421, 5'd5, 3'b101, 5'd4, OP_IMM), 64'h1008, op_srai,
			64'd33, 5'd4, 5'd5, 5'd0); // shamt 33.
		send(enc_r(7'd0, 5'd17, 5'd16, 3'b000, 5'd15, 7'b0110011), 64'h100c, op_add,
			64'd0, 5'd15, 5'd16, 5'd17);
		send(enc_b(13'h1ff8, 5'd7, 5'd6, 3'b000), 64'h1010, op_beq,
			64'hffff_ffff_ffff_fff8, 5'd0, 5'd6, 5'd7);
		send(enc_j(21'h000800, 5'd1), 64'h1014, op_jal, 64'd2048, 5'd1, 5'd0, 5'd0);
		send(enc_i(12'd16, 5'd9, 3'b011, 5'd8, 7'b0000011), 64'h1018, op_ld,
			64'd16, 5'd8, 5'd9, 5'd0);
		send(enc_s(12'hffc, 5'd10, 5'd11, 3'b010), 64'h101c, op_sw,
			64'hffff_ffff_ffff_fffc, 5'd0, 5'd11, 5'd10);
		send(enc_i(12'h300, 5'd13, 3'b001, 5'd12, 7'b1110011), 64'h1020, op_csrrw,
			64'h300, 5'd12, 5'd13, 5'd0);
		send(enc_i(12'hc00, 5'd5, 3'b110, 5'd14, 7'b1110011), 64'h1024, op_csrrsi,
			64'hc00, 5'd14, 5'd0, 5'd0);
		send(32'h0000_0073, 64'h1028, op_ecall, 64'd0, 5'd0, 5'd0, 5'd0);
		send(32'hffff_ffff, 64'h102c, op_illegal, 64'd0, 5'd0, 5'd0, 5'd0);
		idle();
		compare_issued(1'b0);
		release_all();
		finish_test("classification", err0);
	endtask

	task automatic test_rename();
		int err0;
		err0 = errors;
		send(enc_i(12'd1, 5'd0, 3'b000, 5'd5, OP_IMM), 64'h2000, op_addi, 64'd1,
			5'd5, 5'd0, 5'd0);
		send(enc_i(12'd1, 5'd5, 3'b000, 5'd5, OP_IMM), 64'h2004, op_addi, 64'd1,
			5'd5, 5'd5, 5'd0);
		send(enc_i(12'd1, 5'd5, 3'b000, 5'd5, OP_IMM), 64'h2008, op_addi, 64'd1,
			5'd5, 5'd5, 5'd0);
		send(enc_r(7'd0, 5'd5, 5'd5, 3'b000, 5'd6, 7'b0110011), 64'h200c, op_add, 64'd0,
			5'd6, 5'd5, 5'd5);
		send(enc_i(12'd7, 5'd5, 3'b000, 5'd0, OP_IMM), 64'h2010, op_addi, 64'd7,
			5'd0, 5'd5, 5'd0); // x0 is never renamed.
		idle();
		compare_issued(1'b0);
		release_all();
		finish_test("renaming", err0);
	endtask

	task automatic test_version_stall();
		int err0;
		int limit;
		logic [31:0] w;
		err0 = errors;
		limit = 2 ** $bits(version_t) - 1;
		w = enc_i(12'd1, 5'd7, 3'b000, 5'd7, OP_IMM);
		for (int i = 0; i < limit; i++)
			send(w, 64'h3000 + 4 * i, op_addi, 64'd1, 5'd7, 5'd7, 5'd0);
		@(negedge CLK);
		instr_valid = 1'b1;
		instr = w;
		pc = 64'h3100;
		checks++;
		for (int i = 0; i < 10; i++) begin
			@(posedge CLK);
			if (instr_ready) begin
				errors++;
				$display("%0t ns: instr_ready high while x7 had no free version", $time);
			end
		end
		commit(5'd7);
		wait_accept(64'h3100, op_addi, 64'd1, 5'd7, 5'd7, 5'd0);
		idle();
		compare_issued(1'b0);
		release_all();
		finish_test("version stall", err0);
	endtask

	task automatic test_latency();
		int err0;
		err0 = errors;
		send(enc_i(12'd3, 5'd9, 3'b000, 5'd9, OP_IMM), 64'h4000, op_addi, 64'd3,
			5'd9, 5'd9, 5'd0);
		idle();
		compare_issued(1'b1);
		release_all();
		finish_test("latency", err0);
	endtask

	task automatic test_backpressure();
		int err0;
		logic [6:0] opc;
		logic [2:0] f3;
		logic [11:0] imm12;
		micro_op_e op;
		arch_reg_t rs1;
		arch_reg_t rd;
		err0 = errors;
		@(posedge CLK);
		rand_stall = 1'b1;
		for (int i = 0; i < 20; i++) begin
			dat_seed = lcg(dat_seed);
			rs1 = dat_seed[30:26];
			imm12 = dat_seed[21:10];
			rd = arch_reg_t'(i + 1); // one version per register.
			case (i % 4)
			0: begin opc = OP_IMM; f3 = 3'b000; op = op_addi; end
			1: begin opc = 7'b0000011; f3 = 3'b010; op = op_lw; end
			2: begin opc = OP_IMM; f3 = 3'b100; op = op_xori; end
			default: begin opc = 7'b1100111; f3 = 3'b000; op = op_jalr; end
			endcase
			send(enc_i(imm12, rs1, f3, rd, opc), 64'h8000_0000 + 4 * i, op,
				{{52{imm12[11]}}, imm12}, rd, rs1, 5'd0);
		end
		idle();
		compare_issued(1'b0);
		@(posedge CLK);
		rand_stall = 1'b0;
		@(negedge CLK);
		{alu_ready, blu_ready, lsu_ready, csr_ready, oth_ready, iorder_ready} = '1;
		release_all();
		finish_test("back-pressure", err0);
	endtask

	initial begin
		CLK = 1'b0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		commit_valid = 1'b0;
		commit_rd = '0;
		{alu_ready, blu_ready, lsu_ready, csr_ready, oth_ready, iorder_ready} = '1;
		rand_stall = 1'b0;
		cyc = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		rdy_seed = SEED;
		dat_seed = SEED;
		for (int i = 0; i < 32; i++) begin
			model_ver[i] = '0;
			model_cnt[i] = 0;
		end
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
		@(posedge CLK);
		checks++;
		if (!instr_ready) begin
			errors++;
			$display("%0t ns: instr_ready stayed low after reset", $time);
		end
		test_classify();
		test_rename();
		test_version_stall();
		test_latency();
		test_backpressure();
		finish_run();
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/dispatch_pkg.sv
logic/rv64_decoder.sv
rename/rename_stage.sv
logic/dispatch_fifo.sv
dispatch/dispatch.sv
logic/dispatch_top.sv
dv/dispatch_assert.sv
dv/dispatch_tb.sv
